/* Bender.yml */
package:
  name: cnn_layer_engine

sources:
  - hdl/cnn_pkg.sv
  - hdl/mem_req_if.sv
  - hdl/tap_if.sv
  - hdl/axi_lite_regs.sv
  - hdl/feature_mem.sv
  - hdl/tile_fetcher.sv
  - hdl/mac_pool_unit.sv
  - hdl/result_writer.sv
  - hdl/cnn_layer_engine.sv
  - target: test
    files:
      - testbench/tb_cnn_layer_engine.sv

/* hdl/axi_lite_regs.sv */
// AXI4-Lite slave with control/status registers and a window onto the feature memory
// One transaction at a time, writes win over reads
`timescale 1ns/1ps

module axi_lite_regs import cnn_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic [11:0]  awaddr,
    input  logic         awvalid,
    output logic         awready,
    input  logic [31:0]  wdata,
    input  logic [3:0]   wstrb,
    input  logic         wvalid,
    output logic         wready,
    output logic [1:0]   bresp,
    output logic         bvalid,
    input  logic         bready,
    input  logic [11:0]  araddr,
    input  logic         arvalid,
    output logic         arready,
    output logic [31:0]  rdata,
    output logic [1:0]   rresp,
    output logic         rvalid,
    input  logic         rready,
    mem_req_if.requester mem,
    output logic         start,
    output logic [3:0]   shift,
    input  logic         done
);

    typedef enum logic [1:0] {S_IDLE, S_WR, S_RD, S_RESP} state_t;

    state_t            state;
    logic              wr_accept;
    logic              rd_accept;
    logic              busy;
    logic              done_q;
    logic              req_q;
    logic [MEM_AW-1:0] addr_q;
    logic [3:0]        wstrb_q;
    feature_word_u     wdata_q;
    logic [31:0]       reg_rdata;

    assign wr_accept = (state == S_IDLE) && awvalid && wvalid;
    assign rd_accept = (state == S_IDLE) && arvalid && !wr_accept;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign arready   = rd_accept;
    assign bresp     = 2'b00;
    assign rresp     = 2'b00;

    assign mem.req      = req_q;
    assign mem.we       = (state == S_WR);
    assign mem.addr     = addr_q;
    assign mem.byte_off = 2'b00;    // Host accesses are always aligned
    assign mem.wstrb    = wstrb_q;
    assign mem.wdata    = wdata_q;

    always_comb begin
        reg_rdata = '0;
        if (araddr == REG_CTRL) begin
            reg_rdata[CTRL_SHIFT_LSB +: 4] = shift;    // Start bit reads as 0
        end else if (araddr == REG_STATUS) begin
            reg_rdata[1:0] = {done_q, busy};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= S_IDLE;
            req_q  <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            start  <= 1'b0;
            shift  <= 4'd0;
            busy   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            start <= 1'b0;
            if (done) begin
                busy   <= 1'b0;
                done_q <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (wr_accept && awaddr[11:7] == MEM_WINDOW[11:7]) begin
                        req_q <= 1'b1;
                        state <= S_WR;
                    end else if (wr_accept) begin
                        bvalid <= 1'b1;
                        state  <= S_RESP;
                        if (awaddr == REG_CTRL && wstrb[0] && !busy) begin
                            shift <= wdata[CTRL_SHIFT_LSB +: 4];
                            if (wdata[CTRL_START_BIT]) begin
                                start  <= 1'b1;
                                busy   <= 1'b1;
                                done_q <= 1'b0;
                            end
                        end
                    end else if (rd_accept && araddr[11:7] == MEM_WINDOW[11:7]) begin
                        req_q <= 1'b1;
                        state <= S_RD;
                    end else if (rd_accept) begin
                        rvalid <= 1'b1;
                        rdata  <= reg_rdata;
                        state  <= S_RESP;
                    end
                end
                S_WR: begin
                    if (mem.gnt) begin
                        req_q  <= 1'b0;
                        bvalid <= 1'b1;
                        state  <= S_RESP;
                    end
                end
                S_RD: begin
                    if (mem.gnt) begin
                        req_q <= 1'b0;
                    end
                    if (mem.rvalid) begin
                        rvalid <= 1'b1;
                        rdata  <= mem.rdata.word;
                        state  <= S_RESP;
                    end
                end
                default: begin
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                        state  <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            addr_q       <= awaddr[6:2];
            wstrb_q      <= wstrb;
            wdata_q.word <= wdata;
        end else if (rd_accept) begin
            addr_q <= araddr[6:2];
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid);

endmodule

/* hdl/cnn_layer_engine.sv */
// Convolution layer engine top with plain AXI4-Lite slave ports
// Host loads image and weights, starts the layer and polls status for done
`timescale 1ns/1ps

module cnn_layer_engine (
    input  logic        clk,
    input  logic        reset,
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [11:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    logic       start;
    logic [3:0] shift;
    logic       done;
    logic       res_valid;
    logic       res_ready;
    logic [7:0] res_data;

    mem_req_if host_mem ();
    mem_req_if fetch_mem ();
    mem_req_if wr_mem ();
    tap_if     fetch_taps ();
    tap_if     mac_taps ();

    axi_lite_regs axi_lite_regs_inst (.*, .mem(host_mem));

    feature_mem feature_mem_inst (
        .clk, .reset, .wr(wr_mem), .fetch(fetch_mem), .host(host_mem)
    );

    tile_fetcher tile_fetcher_inst (
        .clk, .reset, .start, .mem(fetch_mem), .taps(fetch_taps)
    );

    // Tap register stage keeps the tile mux off the multiplier path
    assign fetch_taps.ready = !mac_taps.valid || mac_taps.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            mac_taps.valid <= 1'b0;
        end else if (fetch_taps.ready) begin
            mac_taps.valid <= fetch_taps.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_taps.valid && fetch_taps.ready) begin
            mac_taps.first  <= fetch_taps.first;
            mac_taps.last   <= fetch_taps.last;
            mac_taps.pix    <= fetch_taps.pix;
            mac_taps.weight <= fetch_taps.weight;
            mac_taps.bias   <= fetch_taps.bias;
        end
    end

    mac_pool_unit mac_pool_unit_inst (
        .clk, .reset, .taps(mac_taps), .shift, .res_valid, .res_data, .res_ready
    );

    result_writer result_writer_inst (
        .clk, .reset, .start, .res_valid, .res_data, .res_ready, .mem(wr_mem), .done
    );

endmodule

/* hdl/cnn_pkg.sv */
// Sizes, register map, memory map and the feature word type of the layer engine
// Imported by every block that touches the feature memory or the host registers
package cnn_pkg;

    localparam int PIX_W     = 8;
    localparam int IMG_DIM   = 8;
    localparam int TILE_GRID = 3;   // Also the pooled output side
    localparam int NUM_TILES = 9;
    localparam int TAPS      = 9;
    localparam int ACC_W     = 20;
    localparam int MEM_WORDS = 32;
    localparam int MEM_AW    = 5;

    // Word map of the feature memory
    localparam logic [MEM_AW-1:0] IMG_BASE = 5'd0;    // Words 0 to 15, two per row
    localparam logic [MEM_AW-1:0] WGT_BASE = 5'd16;   // Nine weights then bias in byte 9
    localparam logic [MEM_AW-1:0] RES_BASE = 5'd20;

    // Host byte addresses
    localparam logic [11:0] REG_CTRL   = 12'h000;
    localparam logic [11:0] REG_STATUS = 12'h004;
    localparam logic [11:0] MEM_WINDOW = 12'h100;

    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_SHIFT_LSB = 4;

    // Host sees a word, the banks see one pixel per lane
    typedef union packed {
        logic [31:0]            word;
        logic [3:0][PIX_W-1:0]  bytes;
    } feature_word_u;

endpackage

/* hdl/feature_mem.sv */
// Feature memory of four byte banks shared by writer, fetcher and host
// Fixed priority arbiter, unaligned reads come back rotated into column order
`timescale 1ns/1ps

module feature_mem import cnn_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    mem_req_if.memory wr,
    mem_req_if.memory fetch,
    mem_req_if.memory host
);

    logic [PIX_W-1:0]             bank [4][MEM_WORDS];
    logic                         any_req;
    logic                         sel_we;
    logic [MEM_AW-1:0]            sel_addr;
    logic [1:0]                   sel_off;
    logic [3:0]                   sel_strb;
    feature_word_u                sel_wdata;
    logic [3:0][MEM_AW-1:0]       bank_addr;
    logic [3:0][PIX_W-1:0]        bank_q;
    logic [1:0]                   off_q;
    logic [2:0]                   rd_owner;    // Host, fetch, writer
    feature_word_u                rdata;

    assign any_req   = wr.req || fetch.req || host.req;
    assign wr.gnt    = wr.req;
    assign fetch.gnt = fetch.req && !wr.req;
    assign host.gnt  = host.req && !wr.req && !fetch.req;

    always_comb begin
        sel_we    = host.we;
        sel_addr  = host.addr;
        sel_off   = host.byte_off;
        sel_strb  = host.wstrb;
        sel_wdata = host.wdata;
        if (wr.req) begin
            sel_we    = wr.we;
            sel_addr  = wr.addr;
            sel_off   = wr.byte_off;
            sel_strb  = wr.wstrb;
            sel_wdata = wr.wdata;
        end else if (fetch.req) begin
            sel_we    = fetch.we;
            sel_addr  = fetch.addr;
            sel_off   = fetch.byte_off;
            sel_strb  = fetch.wstrb;
            sel_wdata = fetch.wdata;
        end
        // Banks below the offset already belong to the next word
        for (int b = 0; b < 4; b++) begin
            bank_addr[b] = sel_addr + MEM_AW'(2'(b) < sel_off);
        end
        for (int i = 0; i < 4; i++) begin
            rdata.bytes[i] = bank_q[2'(i) + off_q];
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (any_req && sel_we && sel_strb[b]) begin
                bank[b][bank_addr[b]] <= sel_wdata.bytes[b];
            end
            bank_q[b] <= bank[b][bank_addr[b]];
        end
        off_q <= sel_off;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_owner <= 3'b000;
        end else begin
            rd_owner <= {host.gnt, fetch.gnt, wr.gnt} & {3{!sel_we}};
        end
    end

    assign wr.rvalid    = rd_owner[0];
    assign fetch.rvalid = rd_owner[1];
    assign host.rvalid  = rd_owner[2];
    assign wr.rdata     = rdata;
    assign fetch.rdata  = rdata;
    assign host.rdata   = rdata;

    // Lower priority requesters keep asking at the same word until served
    a_fetch_hold: assert property (@(posedge clk) disable iff (reset)
        fetch.req && !fetch.gnt |=> fetch.req && $stable(fetch.addr));
    a_host_hold: assert property (@(posedge clk) disable iff (reset)
        host.req && !host.gnt |=> host.req && $stable(host.addr));

endmodule

/* hdl/mac_pool_unit.sv */
// Four parallel MACs, then ReLU, 2x2 max pool and shift with saturation to a byte
`timescale 1ns/1ps

module mac_pool_unit import cnn_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    tap_if.sink              taps,
    input  logic [3:0]       shift,
    output logic             res_valid,
    output logic [PIX_W-1:0] res_data,
    input  logic             res_ready
);

    logic signed [ACC_W-1:0] acc [4];
    logic signed [ACC_W-1:0] prod [4];
    logic signed [ACC_W-1:0] bias_ext;
    logic signed [ACC_W-1:0] pool;
    logic [ACC_W-1:0]        scaled;
    logic                    fin;        // Sums complete, pool next cycle

    assign taps.ready = !res_valid;
    assign bias_ext   = {{(ACC_W - PIX_W){taps.bias[PIX_W-1]}}, taps.bias};

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            prod[p] = $signed({1'b0, taps.pix[p]}) * taps.weight;
        end
        pool = '0;    // Zero floor acts as the ReLU
        for (int p = 0; p < 4; p++) begin
            if (acc[p] > pool) begin
                pool = acc[p];
            end
        end
        scaled = unsigned'(pool) >> shift;
    end

    always_ff @(posedge clk) begin
        if (taps.valid && taps.ready) begin
            for (int p = 0; p < 4; p++) begin
                acc[p] <= (taps.first ? bias_ext : acc[p]) + prod[p];
            end
        end
        if (fin) begin
            res_data <= (scaled > ACC_W'(255)) ? 8'hff : scaled[PIX_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fin       <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            fin <= taps.valid && taps.ready && taps.last;
            if (fin) begin
                res_valid <= 1'b1;
            end else if (res_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    a_res_stable: assert property (@(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> $stable(res_data));

endmodule

/* hdl/mem_req_if.sv */
// One requester port of the shared feature memory
// Requester holds its fields until gnt, read data returns the cycle after gnt
`timescale 1ns/1ps

interface mem_req_if import cnn_pkg::*; ();

    logic              req;
    logic              we;
    logic [MEM_AW-1:0] addr;
    logic [1:0]        byte_off;    // Column offset of an unaligned read
    logic [3:0]        wstrb;
    feature_word_u     wdata;
    logic              gnt;
    logic              rvalid;
    feature_word_u     rdata;

    modport requester (output req, we, addr, byte_off, wstrb, wdata,
                       input gnt, rvalid, rdata);
    modport memory (input req, we, addr, byte_off, wstrb, wdata,
                    output gnt, rvalid, rdata);

endinterface

/* hdl/result_writer.sv */
// Writes each pooled byte into the result region and pulses done after the last
`timescale 1ns/1ps

module result_writer import cnn_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             res_valid,
    input  logic [PIX_W-1:0] res_data,
    output logic             res_ready,
    mem_req_if.requester     mem,
    output logic             done
);

    logic             req_q;
    logic [3:0]       cnt;       // Index of the next result
    logic [PIX_W-1:0] data_q;

    assign res_ready       = !req_q;
    assign mem.req         = req_q;
    assign mem.we          = 1'b1;
    assign mem.addr        = RES_BASE + MEM_AW'(cnt[3:2]);
    assign mem.byte_off    = 2'b00;
    assign mem.wstrb       = 4'b0001 << cnt[1:0];
    assign mem.wdata.bytes = {4{data_q}};

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= 1'b0;
            cnt   <= 4'd0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                cnt <= 4'd0;
            end
            if (res_valid && res_ready) begin
                req_q <= 1'b1;
            end
            if (mem.gnt) begin
                req_q <= 1'b0;
                cnt   <= cnt + 4'd1;
                done  <= (cnt == 4'(NUM_TILES - 1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            data_q <= res_data;
        end
    end

endmodule

/* hdl/tap_if.sv */
// Window taps for four output positions plus one weight per beat
`timescale 1ns/1ps

interface tap_if import cnn_pkg::*; ();

    logic                    valid;
    logic                    first;     // First tap of a tile
    logic                    last;      // Ninth tap
    logic [3:0][PIX_W-1:0]   pix;
    logic signed [PIX_W-1:0] weight;
    logic signed [PIX_W-1:0] bias;      // Used with first
    logic                    ready;

    modport source (output valid, first, last, pix, weight, bias, input ready);
    modport sink (input valid, first, last, pix, weight, bias, output ready);

endinterface

/* hdl/tile_fetcher.sv */
// Layer sequencer: loads weights and bias, then walks the 3x3 tile grid
// Each 4x4 tile is streamed as nine tap beats for four window positions
`timescale 1ns/1ps

module tile_fetcher import cnn_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    mem_req_if.requester mem,
    tap_if.source        taps
);

    typedef enum logic [1:0] {F_IDLE, F_WGT, F_ROW, F_TAP} state_t;

    state_t                     state;
    logic                       req_q;
    logic [1:0]                 rd_cnt;    // Weight word or tile row
    logic [1:0]                 ti;
    logic [1:0]                 tj;
    logic [1:0]                 dy;
    logic [1:0]                 dx;
    logic [2:0]                 img_row;
    logic [3:0]                 wi;
    logic [11:0][PIX_W-1:0]     wbytes;    // Bias sits in byte 9
    logic [3:0][3:0][PIX_W-1:0] tile;

    assign img_row = {ti, 1'b0} + {1'b0, rd_cnt};
    assign wi      = 4'(dy) * 4'd3 + 4'(dx);

    assign mem.req   = req_q;
    assign mem.we    = 1'b0;
    assign mem.wstrb = 4'b0000;
    assign mem.wdata = '0;
    assign mem.addr  = (state == F_WGT) ? WGT_BASE + MEM_AW'(rd_cnt)
                     : IMG_BASE + MEM_AW'(img_row * (IMG_DIM / 4)) + MEM_AW'(tj[1]);
    assign mem.byte_off = (state == F_WGT) ? 2'b00 : {tj[0], 1'b0};  // Middle column is mid-word

    assign taps.valid  = (state == F_TAP);
    assign taps.first  = (wi == 4'd0);
    assign taps.last   = (wi == 4'(TAPS - 1));
    assign taps.weight = wbytes[wi];
    assign taps.bias   = wbytes[9];

    // Positions (0,0) (0,1) (1,0) (1,1)
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            taps.pix[p] = tile[dy + 2'(p / 2)][dx + 2'(p % 2)];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= F_IDLE;
            req_q  <= 1'b0;
            rd_cnt <= 2'd0;
            ti     <= 2'd0;
            tj     <= 2'd0;
            dy     <= 2'd0;
            dx     <= 2'd0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (start) begin
                        state  <= F_WGT;
                        req_q  <= 1'b1;
                        rd_cnt <= 2'd0;
                        ti     <= 2'd0;
                        tj     <= 2'd0;
                    end
                end
                F_WGT, F_ROW: begin
                    if (mem.gnt) begin
                        req_q <= 1'b0;
                    end
                    if (mem.rvalid) begin
                        rd_cnt <= rd_cnt + 2'd1;
                        req_q  <= 1'b1;
                        if (state == F_WGT && rd_cnt == 2'd2) begin
                            state  <= F_ROW;
                            rd_cnt <= 2'd0;
                        end else if (state == F_ROW && rd_cnt == 2'd3) begin
                            state <= F_TAP;
                            req_q <= 1'b0;
                        end
                    end
                end
                default: begin
                    if (taps.ready) begin
                        dx <= (dx == 2'd2) ? 2'd0 : dx + 2'd1;
                        if (dx == 2'd2) begin
                            dy <= (dy == 2'd2) ? 2'd0 : dy + 2'd1;
                        end
                        if (taps.last) begin    // Next tile in row-major order
                            tj <= (tj == 2'(TILE_GRID - 1)) ? 2'd0 : tj + 2'd1;
                            if (tj == 2'(TILE_GRID - 1)) begin
                                ti <= ti + 2'd1;
                            end
                            if (ti == 2'(TILE_GRID - 1) && tj == 2'(TILE_GRID - 1)) begin
                                state <= F_IDLE;
                            end else begin
                                state <= F_ROW;
                                req_q <= 1'b1;
                            end
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem.rvalid && state == F_WGT) begin
            wbytes[{rd_cnt, 2'b00} +: 4] <= mem.rdata.bytes;
        end
        if (mem.rvalid && state == F_ROW) begin
            tile[rd_cnt] <= mem.rdata.bytes;
        end
    end

endmodule

/* testbench/tb_cnn_layer_engine.sv */
// Self-checking testbench for the convolution layer engine, driven over AXI4-Lite
// Loads layers through the memory window, runs them to done and checks against a model
`timescale 1ns/1ps

module tb_cnn_layer_engine import cnn_pkg::*; ();

    logic        clk;
    logic        reset;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    int          img_px [IMG_DIM][IMG_DIM];   // Unsigned pixels 0..255
    int          wgt [TAPS];                  // Signed weights
    int          bias_v;
    logic [31:0] seed;
    string       cur_test;
    int          errors;
    int          test_errors;
    int          checks;
    string       name_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];
    string       c_name;
    logic [31:0] c_exp;
    logic [31:0] c_act;

    cnn_layer_engine cnn_layer_engine_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Budget of 2000 cycles for each of the five tests
    initial begin
        #(5 * 2000 * 100);
        $display("Watchdog expired, the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Four window positions per tile, ReLU through the zero floor, max, shift, clamp
    function automatic logic [NUM_TILES-1:0][7:0] ref_layer(input int sh);
        logic [NUM_TILES-1:0][7:0] res;
        int acc;
        int best;
        int r0;
        int c0;
        for (int k = 0; k < NUM_TILES; k++) begin
            best = 0;
            r0   = 2 * (k / TILE_GRID);
            c0   = 2 * (k % TILE_GRID);
            for (int p = 0; p < 4; p++) begin
                acc = bias_v;
                for (int t = 0; t < TAPS; t++) begin
                    acc += img_px[r0 + p / 2 + t / 3][c0 + p % 2 + t % 3] * wgt[t];
                end
                if (acc > best) begin
                    best = acc;
                end
            end
            best   = best >> sh;
            res[k] = (best > 255) ? 8'hff : 8'(best);
        end
        return res;
    endfunction

    function automatic logic [11:0] word_addr(input int w);
        return MEM_WINDOW + 12'(4 * w);
    endfunction

    // Row r in words 2r and 2r+1, column c in byte c mod 4
    function automatic logic [31:0] image_word(input int w);
        logic [31:0] v;
        for (int b = 0; b < 4; b++) begin
            v[8*b +: 8] = 8'(img_px[w / 2][4 * (w % 2) + b]);
        end
        return v;
    endfunction

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        #1;
        while (!(awready && wready)) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);    // Handshake took place on the rising edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) begin
            @(negedge clk);
        end
        push_check($sformatf("bresp at %h", addr), 32'h0, 32'(bresp));
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) begin
            @(negedge clk);
        end
        data = rdata;
        push_check($sformatf("rresp at %h", addr), 32'h0, 32'(rresp));
    endtask

    task automatic push_check(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        @(negedge clk);    // Compare process drains on the rising edge before this
        $display("%s: %s, %0d error(s)", cur_test, (test_errors == 0) ? "ok" : "failed",
                 test_errors);
    endtask

    task automatic randomize_layer();
        for (int r = 0; r < IMG_DIM; r++) begin
            for (int c = 0; c < IMG_DIM; c++) begin
                seed        = xorshift(seed);
                img_px[r][c] = int'(seed[7:0]);
            end
        end
        for (int t = 0; t < TAPS; t++) begin
            seed   = xorshift(seed);
            wgt[t] = int'($signed(seed[15:8]));
        end
        seed   = xorshift(seed);
        bias_v = int'($signed(seed[23:16]));
    endtask

    task automatic load_layer();
        for (int w = 0; w < 2 * IMG_DIM; w++) begin
            axi_write(word_addr(w), image_word(w), 4'hf);
        end
        axi_write(word_addr(WGT_BASE),
                  {8'(wgt[3]), 8'(wgt[2]), 8'(wgt[1]), 8'(wgt[0])}, 4'hf);
        axi_write(word_addr(WGT_BASE + 1),
                  {8'(wgt[7]), 8'(wgt[6]), 8'(wgt[5]), 8'(wgt[4])}, 4'hf);
        axi_write(word_addr(WGT_BASE + 2), {16'h0000, 8'(bias_v), 8'(wgt[8])}, 4'hf);
    endtask

    task automatic start_layer(input logic [3:0] sh);
        axi_write(REG_CTRL, {24'h0, sh, 4'b0001}, 4'b0001);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int polls;
        polls = 0;
        st    = '0;
        while (!st[1] && polls < 1000) begin
            axi_read(REG_STATUS, st);
            polls++;
        end
        assert (st[1]) else begin
            $display("%s: status never showed done after %0d polls", cur_test, polls);
            errors++;
            test_errors++;
        end
    endtask

    // Result k in byte k mod 4 of word RES_BASE + k/4
    task automatic check_results(input logic [NUM_TILES-1:0][7:0] exp);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < NUM_TILES; k++) begin
            if (k % 4 == 0) begin
                axi_read(word_addr(RES_BASE + k / 4), w);
            end
            push_check($sformatf("result %0d", k), 32'(exp[k]), 32'(w[8*(k%4) +: 8]));
        end
    endtask

    // Compare process
    always @(posedge clk) begin
        while (exp_q.size() > 0) begin
            c_name = name_q.pop_front();
            c_exp  = exp_q.pop_front();
            c_act  = act_q.pop_front();
            checks++;
            assert (c_act === c_exp) else begin
                $display("ERROR %s %s: expected %h actual %h", cur_test, c_name, c_exp, c_act);
                errors++;
                test_errors++;
            end
        end
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] base;
        logic [31:0] upd;
        logic [31:0] expw;
        logic [3:0]  strb;
        reset       = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b1;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b1;
        seed        = 32'h7d21_49c2;
        errors      = 0;
        test_errors = 0;
        checks      = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        begin_test("reset_values");
        axi_read(REG_CTRL, rd);
        push_check("control", 32'h0, rd);
        axi_read(REG_STATUS, rd);
        push_check("status", 32'h0, rd);
        end_test();

        begin_test("mem_strobes");
        for (int w = RES_BASE + 3; w < MEM_WORDS; w++) begin    // Words the layer never uses
            seed = xorshift(seed);
            base = seed;
            seed = xorshift(seed);
            upd  = seed;
            strb = seed[31:28];
            axi_write(word_addr(w), base, 4'hf);
            axi_write(word_addr(w), upd, strb);
            for (int b = 0; b < 4; b++) begin
                expw[8*b +: 8] = strb[b] ? upd[8*b +: 8] : base[8*b +: 8];
            end
            axi_read(word_addr(w), rd);
            push_check($sformatf("word %0d", w), expw, rd);
        end
        end_test();

        begin_test("layer_random");
        randomize_layer();
        load_layer();
        start_layer(4'd8);
        wait_done();
        check_results(ref_layer(8));
        axi_read(REG_STATUS, rd);
        push_check("status after done", 32'h2, rd);
        end_test();

        begin_test("layer_saturate");
        for (int r = 0; r < IMG_DIM; r++) begin
            for (int c = 0; c < IMG_DIM; c++) begin
                seed         = xorshift(seed);
                img_px[r][c] = 240 + int'(seed[3:0]);    // Bright pixels
            end
        end
        for (int t = 0; t < TAPS; t++) begin
            seed   = xorshift(seed);
            wgt[t] = 1 + int'(seed[6:0]) % 127;
        end
        bias_v = int'(seed[13:8]);
        load_layer();
        start_layer(4'd0);
        wait_done();
        check_results({NUM_TILES{8'hff}});
        for (int t = 0; t < TAPS; t++) begin
            seed   = xorshift(seed);
            wgt[t] = -1 - int'(seed[6:0]);
        end
        bias_v = -1 - int'(seed[14:8]);
        load_layer();
        start_layer(4'd0);
        wait_done();
        check_results('0);
        end_test();

        begin_test("run_busy");
        randomize_layer();
        load_layer();
        start_layer(4'd6);
        axi_read(REG_STATUS, rd);
        push_check("status busy", 32'h1, rd);
        start_layer(4'd2);    // Dropped while busy, shift stays 6
        axi_read(REG_CTRL, rd);
        push_check("shift kept", 32'h60, rd);
        seed = xorshift(seed);
        axi_write(word_addr(27), seed, 4'hf);
        axi_read(word_addr(27), rd);
        push_check("spare word", seed, rd);
        axi_read(word_addr(5), rd);
        push_check("image word 5", image_word(5), rd);
        wait_done();
        check_results(ref_layer(6));
        end_test();

        $display("Finished 5 tests: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/cnn_pkg.sv
hdl/mem_req_if.sv
hdl/tap_if.sv
hdl/axi_lite_regs.sv
hdl/feature_mem.sv
hdl/tile_fetcher.sv
hdl/mac_pool_unit.sv
hdl/result_writer.sv
hdl/cnn_layer_engine.sv
testbench/tb_cnn_layer_engine.sv
